// ==== common/csr_pkg.sv ====
package csr_pkg;

    // Data and address widths
    typedef logic [31:0] xlen_t;     // One machine word
    typedef logic [11:0] csr_addr_t; // CSR address field of the instruction
    typedef logic [63:0] dword_t;    // Memory-mapped timer value

    // CSR operation presented with csr_valid
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1, // csrrw
        CMD_S     = 3'd2, // csrrs
        CMD_C     = 3'd3, // csrrc
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_t;

    // Privilege levels, encoded as in the privileged spec
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_t;

    // Machine trap setup
    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MIE      = 12'h304;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;

    // Machine trap handling
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MIP      = 12'h344;

    // mcause values, interrupt flag in bit 31
    localparam xlen_t CAUSE_ECALL_U     = 32'd8;
    localparam xlen_t CAUSE_ECALL_M     = 32'd11;
    localparam xlen_t CAUSE_M_TIMER_IRQ = 32'h8000_0007;

    // mtvec.MODE encoding, direct is 2'b00
    localparam logic [1:0] TVEC_VECTORED = 2'b01;

    // MXL = 1 (32 bit), extensions I and M
    //                           MXL      ZYXWVUTSRQPONMLKJIHGFEDCBA
    localparam xlen_t MISA_VALUE = {2'b01, 4'b0000, 26'b00000000000001000100000000};

endpackage

// ==== common/csr_rw_if.sv ====
`timescale 1ns/1ps

// CSR read and write path between decode and the register file
interface csr_rw_if;
    import csr_pkg::*;

    csr_addr_t addr;  // Address of the current access
    xlen_t     wdata; // Value after the write, set or clear
    logic      we;    // One-cycle write strobe, already privilege-checked
    xlen_t     rdata; // Unmasked read mux output
    priv_t     mode;  // Current privilege level for the access check

    modport access (
        output addr, wdata, we,
        input  rdata, mode
    );

    modport file (
        input  addr, wdata, we,
        output rdata, mode
    );

endinterface

// ==== common/trap_if.sv ====
`timescale 1ns/1ps

// Trap entry and MRET requests, plus the state the trap logic looks at
interface trap_if;
    import csr_pkg::*;

    logic  take_trap;   // Enter M-mode trap this cycle
    xlen_t cause;       // Value for mcause
    logic  do_mret;     // Return from trap

    priv_t mode;
    logic  mstatus_mie; // Global enable while in M-mode
    logic  mie_mtie;
    logic  mip_mtip;    // Registered timer compare
    xlen_t mtvec;
    xlen_t mepc;        // MRET target

    modport ctrl (
        output take_trap, cause, do_mret,
        input  mode, mstatus_mie, mie_mtie, mip_mtip, mtvec, mepc
    );

    modport file (
        input  take_trap, cause, do_mret,
        output mode, mstatus_mie, mie_mtie, mip_mtip, mtvec, mepc
    );

endinterface

// ==== src/csr_access.sv ====
`timescale 1ns/1ps

module csr_access (
    input  logic                csr_valid,
    input  csr_pkg::csr_cmd_t   csr_cmd,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::xlen_t      csr_operand,
    output csr_pkg::xlen_t      csr_rdata,
    csr_rw_if.access            rw
);
    import csr_pkg::*;

    logic  can_read;
    logic  can_write;
    logic  is_rw_cmd;
    xlen_t rdata_ok;

    // Bits 9:8 give the lowest level allowed, 11:10 == 3 marks read-only space
    assign can_read  = csr_addr[9:8] <= rw.mode;
    assign can_write = can_read && (csr_addr[11:10] != 2'b11);

    assign is_rw_cmd = (csr_cmd == CMD_W) || (csr_cmd == CMD_S) || (csr_cmd == CMD_C);

    assign rw.addr   = csr_addr;
    assign rdata_ok  = can_read ? rw.rdata : '0; // Denied read gives zero
    assign csr_rdata = rdata_ok;

    // New CSR value from the old one
    always_comb begin
        case (csr_cmd)
            CMD_W:   rw.wdata = csr_operand;
            CMD_S:   rw.wdata = rdata_ok | csr_operand;
            CMD_C:   rw.wdata = rdata_ok & ~csr_operand;
            default: rw.wdata = rdata_ok; // No change
        endcase
    end

    // Denied writes are dropped silently
    assign rw.we = csr_valid && is_rw_cmd && can_write;

endmodule

// ==== src/csr_file.sv ====
`timescale 1ns/1ps

module csr_file #(
    parameter csr_pkg::xlen_t RESET_VECTOR = 32'h0000_0100
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             csr_valid,
    input  csr_pkg::xlen_t   csr_pc,
    input  csr_pkg::dword_t  mtime,
    input  csr_pkg::dword_t  mtimecmp,
    output csr_pkg::priv_t   priv_mode,
    csr_rw_if.file           rw,
    trap_if.file             tr
);
    import csr_pkg::*;

    priv_t mode_q;         // Current privilege level
    logic  mstatus_mie;
    logic  mstatus_mpie;
    priv_t mstatus_mpp;    // Only U or M can be stored
    logic  mie_mtie;
    logic  mip_mtip;
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mstatus_word;

    // MPP at 12:11, MPIE at 7, MIE at 3, everything else reads zero
    assign mstatus_word = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};

    always_comb begin
        case (rw.addr)
            ADDR_MSTATUS:  rw.rdata = mstatus_word;
            ADDR_MISA:     rw.rdata = MISA_VALUE;
            ADDR_MIE:      rw.rdata = {24'b0, mie_mtie, 7'b0}; // MTIE at bit 7
            ADDR_MTVEC:    rw.rdata = mtvec;
            ADDR_MSCRATCH: rw.rdata = mscratch;
            ADDR_MEPC:     rw.rdata = mepc;
            ADDR_MCAUSE:   rw.rdata = mcause;
            ADDR_MIP:      rw.rdata = {24'b0, mip_mtip, 7'b0}; // MTIP at bit 7
            default:       rw.rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_q       <= PRIV_M;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_U;
            mie_mtie     <= 1'b0;
            mip_mtip     <= 1'b0;
            mtvec        <= RESET_VECTOR;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else if (tr.take_trap) begin
            // Trap entry beats any write or MRET in the same cycle
            mcause       <= tr.cause;
            mepc         <= csr_pc;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= mode_q;
            mode_q       <= PRIV_M;
            if (tr.cause == CAUSE_M_TIMER_IRQ)
                mip_mtip <= 1'b0; // Serviced, resampled on a later command
        end else begin
            if (csr_valid)
                mip_mtip <= mtime >= mtimecmp;
            if (tr.do_mret) begin
                mstatus_mie  <= mstatus_mpie;
                mode_q       <= mstatus_mpp;
                mstatus_mpie <= 1'b1;
                mstatus_mpp  <= PRIV_U; // Least privileged mode
            end
            if (rw.we) begin
                case (rw.addr)
                    ADDR_MSTATUS: begin
                        mstatus_mie  <= rw.wdata[3];
                        mstatus_mpie <= rw.wdata[7];
                        // Unsupported levels fall back to U
                        mstatus_mpp  <= (rw.wdata[12:11] == 2'b11) ? PRIV_M : PRIV_U;
                    end
                    ADDR_MIE:      mie_mtie <= rw.wdata[7];
                    ADDR_MTVEC:    mtvec    <= {rw.wdata[31:2], 1'b0, rw.wdata[0]}; // Modes 0/1
                    ADDR_MSCRATCH: mscratch <= rw.wdata;
                    ADDR_MEPC:     mepc     <= {rw.wdata[31:2], 2'b00};
                    ADDR_MCAUSE:   mcause   <= rw.wdata;
                    default: begin
                    end // misa and mip are read-only here
                endcase
            end
        end
    end

    assign priv_mode      = mode_q;
    assign rw.mode        = mode_q;
    assign tr.mode        = mode_q;
    assign tr.mstatus_mie = mstatus_mie;
    assign tr.mie_mtie    = mie_mtie;
    assign tr.mip_mtip    = mip_mtip;
    assign tr.mtvec       = mtvec;
    assign tr.mepc        = mepc;

endmodule

// ==== src/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl (
    input  logic               csr_valid,
    input  csr_pkg::csr_cmd_t  csr_cmd,
    output logic               trap_flg,
    output csr_pkg::xlen_t     trap_vector,
    trap_if.ctrl               tr
);
    import csr_pkg::*;

    logic  is_ecall;
    logic  is_mret;
    logic  global_ie;
    logic  irq_pending;
    xlen_t tvec_base;
    xlen_t tvec_addr;

    assign is_ecall = csr_cmd == CMD_ECALL;
    assign is_mret  = csr_cmd == CMD_MRET;

    // Lower privilege is always interruptible by M-level sources
    assign global_ie   = (tr.mode == PRIV_M) ? tr.mstatus_mie : 1'b1;
    assign irq_pending = tr.mip_mtip && tr.mie_mtie && global_ie;

    assign tr.take_trap = csr_valid && (is_ecall || irq_pending);
    assign tr.do_mret   = csr_valid && is_mret;

    // Ecall wins over a pending timer interrupt
    always_comb begin
        if (is_ecall)
            tr.cause = (tr.mode == PRIV_M) ? CAUSE_ECALL_M : CAUSE_ECALL_U;
        else
            tr.cause = CAUSE_M_TIMER_IRQ;
    end

    assign tvec_base = {tr.mtvec[31:2], 2'b00};

    // Vectored mode offsets interrupts only, exceptions use the base
    always_comb begin
        if (tr.mtvec[1:0] == TVEC_VECTORED && !is_ecall)
            tvec_addr = tvec_base + {tr.cause[29:0], 2'b00}; // Cause code times 4
        else
            tvec_addr = tvec_base;
    end

    assign trap_flg    = tr.take_trap || tr.do_mret;
    assign trap_vector = tr.take_trap ? tvec_addr :
                         tr.do_mret   ? tr.mepc   : '0; // Zero when idle

endmodule

// ==== src/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit #(
    parameter csr_pkg::xlen_t RESET_VECTOR = 32'h0000_0100
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               csr_valid,
    input  csr_pkg::csr_cmd_t  csr_cmd,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::xlen_t     csr_operand,
    input  csr_pkg::xlen_t     csr_pc,
    input  csr_pkg::dword_t    mtime,
    input  csr_pkg::dword_t    mtimecmp,
    output csr_pkg::xlen_t     csr_rdata,
    output logic               trap_flg,
    output csr_pkg::xlen_t     trap_vector,
    output csr_pkg::priv_t     priv_mode
);

    csr_rw_if rw_bus ();   // Decode to register file
    trap_if   trap_bus (); // Trap decisions and state they depend on

    csr_access u_access (
        .csr_valid   (csr_valid),
        .csr_cmd     (csr_cmd),
        .csr_addr    (csr_addr),
        .csr_operand (csr_operand),
        .csr_rdata   (csr_rdata),
        .rw          (rw_bus.access)
    );

    csr_file #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .csr_valid (csr_valid),
        .csr_pc    (csr_pc),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .priv_mode (priv_mode),
        .rw        (rw_bus.file),
        .tr        (trap_bus.file)
    );

    trap_ctrl u_trap (
        .csr_valid   (csr_valid),
        .csr_cmd     (csr_cmd),
        .trap_flg    (trap_flg),
        .trap_vector (trap_vector),
        .tr          (trap_bus.ctrl)
    );

endmodule

// ==== tb/csr_assertions.sv ====
`timescale 1ns/1ps

module csr_assertions (
    input logic               clk,
    input logic               arst_n,
    input logic               csr_valid,
    input logic               trap_flg,
    input csr_pkg::xlen_t     trap_vector,
    input csr_pkg::priv_t     priv_mode
);
    import csr_pkg::*;

    // No trap or return without a command
    idle_no_trap: assert property (@(posedge clk) disable iff (!arst_n)
        !csr_valid |-> !trap_flg)
        else $error("trap_flg high without csr_valid");

    idle_vector_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !csr_valid |-> (trap_vector == '0 || $stable(trap_vector)))
        else $error("trap_vector moved without csr_valid");

    // Only two privilege levels exist
    mode_legal: assert property (@(posedge clk) disable iff (!arst_n)
        priv_mode inside {PRIV_U, PRIV_M})
        else $error("priv_mode holds an unsupported level");

endmodule

bind csr_unit csr_assertions u_assertions (
    .clk         (clk),
    .arst_n      (arst_n),
    .csr_valid   (csr_valid),
    .trap_flg    (trap_flg),
    .trap_vector (trap_vector),
    .priv_mode   (priv_mode)
);

// ==== tb/csr_checker.sv ====
`timescale 1ns/1ps

module csr_checker #(
    parameter csr_pkg::xlen_t RESET_VECTOR = 32'h0000_0100
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               csr_valid,
    input  csr_pkg::csr_cmd_t  csr_cmd,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::xlen_t     csr_operand,
    input  csr_pkg::xlen_t     csr_pc,
    input  csr_pkg::dword_t    mtime,
    input  csr_pkg::dword_t    mtimecmp,
    input  csr_pkg::xlen_t     csr_rdata,
    input  logic               trap_flg,
    input  csr_pkg::xlen_t     trap_vector,
    input  csr_pkg::priv_t     priv_mode,
    output int                 mismatches
);
    import csr_pkg::*;

    // Architectural state as software sees it
    typedef struct packed {
        priv_t mode;
        logic  mie;
        logic  mpie;
        priv_t mpp;
        logic  mtie;
        logic  mtip;
        xlen_t mtvec;
        xlen_t mscratch;
        xlen_t mepc;
        xlen_t mcause;
    } shadow_t;

    shadow_t cur;
    shadow_t nxt;
    xlen_t   exp_rdata;
    logic    exp_flg;
    xlen_t   exp_vec;

    // Expected outputs of one command and the state after it
    function automatic shadow_t predict(input csr_cmd_t cmd, input csr_addr_t addr,
                                       input xlen_t operand, input xlen_t pc,
                                       input logic timer_hit, input shadow_t st,
                                       output xlen_t rd, output logic flg, output xlen_t vec);
        shadow_t ns;
        xlen_t   word;
        xlen_t   wdata;
        xlen_t   cause;
        logic    rd_ok;
        logic    irq;
        logic    trap;
        ns   = st;
        word = '0;
        case (addr)
            ADDR_MSTATUS: begin
                word[12:11] = st.mpp;
                word[7]     = st.mpie;
                word[3]     = st.mie;
            end
            ADDR_MISA:     word = MISA_VALUE;
            ADDR_MIE:      word[7] = st.mtie;
            ADDR_MTVEC:    word = st.mtvec;
            ADDR_MSCRATCH: word = st.mscratch;
            ADDR_MEPC:     word = st.mepc;
            ADDR_MCAUSE:   word = st.mcause;
            ADDR_MIP:      word[7] = st.mtip;
            default:       word = '0; // Unknown address
        endcase
        rd_ok = addr[9:8] <= st.mode; // Lowest level allowed
        rd    = rd_ok ? word : '0;
        case (cmd)
            CMD_W:   wdata = operand;
            CMD_S:   wdata = rd | operand;
            CMD_C:   wdata = rd & ~operand;
            default: wdata = rd;
        endcase
        // U-mode always takes M-level interrupts
        irq   = st.mtip && st.mtie && ((st.mode == PRIV_M) ? st.mie : 1'b1);
        trap  = (cmd == CMD_ECALL) || irq;
        cause = (cmd != CMD_ECALL) ? CAUSE_M_TIMER_IRQ :
                (st.mode == PRIV_M) ? CAUSE_ECALL_M : CAUSE_ECALL_U;
        flg   = trap || (cmd == CMD_MRET);
        vec   = '0;
        if (trap) begin
            vec = {st.mtvec[31:2], 2'b00};
            if (st.mtvec[1:0] == 2'b01 && cmd != CMD_ECALL)
                vec = vec + ((cause & 32'h7fff_ffff) << 2); // Interrupt code times 4
            ns.mcause = cause;
            ns.mepc   = pc;
            ns.mpie   = st.mie;
            ns.mie    = 1'b0;
            ns.mpp    = st.mode;
            ns.mode   = PRIV_M;
            if (cause == CAUSE_M_TIMER_IRQ)
                ns.mtip = 1'b0;
        end else begin
            ns.mtip = timer_hit;
            if (cmd == CMD_MRET) begin
                vec     = st.mepc;
                ns.mie  = st.mpie;
                ns.mode = st.mpp;
                ns.mpie = 1'b1;
                ns.mpp  = PRIV_U;
            end
            if (cmd inside {CMD_W, CMD_S, CMD_C} && rd_ok && addr[11:10] != 2'b11) begin
                case (addr)
                    ADDR_MSTATUS: begin
                        ns.mie  = wdata[3];
                        ns.mpie = wdata[7];
                        ns.mpp  = (wdata[12:11] == 2'b11) ? PRIV_M : PRIV_U;
                    end
                    ADDR_MIE:      ns.mtie     = wdata[7];
                    ADDR_MTVEC:    ns.mtvec    = wdata; // Only legal modes are written
                    ADDR_MSCRATCH: ns.mscratch = wdata;
                    ADDR_MEPC:     ns.mepc     = {wdata[31:2], 2'b00};
                    ADDR_MCAUSE:   ns.mcause   = wdata;
                    default: begin
                    end
                endcase
            end
        end
        return ns;
    endfunction

    task automatic compare_value(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("ERR %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            cur        = '0; // mstatus, mie, mip and friends clear
            cur.mode   = PRIV_M;
            cur.mtvec  = RESET_VECTOR;
            mismatches = 0;
        end else begin
            compare_value("priv_mode", {30'b0, cur.mode}, {30'b0, priv_mode});
            if (csr_valid) begin
                nxt = predict(csr_cmd, csr_addr, csr_operand, csr_pc, mtime >= mtimecmp,
                              cur, exp_rdata, exp_flg, exp_vec);
                compare_value("csr_rdata", exp_rdata, csr_rdata); // Read mux for any command
                compare_value("trap_flg", {31'b0, exp_flg}, {31'b0, trap_flg});
                compare_value("trap_vector", exp_vec, trap_vector);
                cur = nxt; // Takes effect for the next command
            end
        end
    end

endmodule

// ==== tb/tb_csr_unit.sv ====
`timescale 1ns/1ps

module tb_csr_unit;
    import csr_pkg::*;

    localparam int    PERIOD       = 100;
    localparam xlen_t RESET_VECTOR = 32'h0000_0100;
    localparam int    NUM_RANDOM   = 24;
    localparam int    NUM_CMDS     = 2 * NUM_RANDOM + 40;           // Random pairs plus directed
    localparam int    WATCHDOG_NS  = (NUM_CMDS + 10 + 50) * PERIOD; // Reset and margin

    logic      clk;
    logic      arst_n;
    logic      csr_valid;
    csr_cmd_t  csr_cmd;
    csr_addr_t csr_addr;
    xlen_t     csr_operand;
    xlen_t     csr_pc;
    dword_t    mtime;
    dword_t    mtimecmp;
    xlen_t     csr_rdata;
    logic      trap_flg;
    xlen_t     trap_vector;
    priv_t     priv_mode;
    int        mismatches;

    integer    seed;
    int        seq_errors;
    logic      trap_seen;  // trap_flg of the last command
    xlen_t     pc;
    xlen_t     rnd;
    xlen_t     operand;
    csr_cmd_t  cmd;

    always #(PERIOD / 2) clk = ~clk;

    csr_unit #(.RESET_VECTOR(RESET_VECTOR)) dut0 (.*);

    csr_checker #(.RESET_VECTOR(RESET_VECTOR)) u_checker (.*);

    // One valid command, driven on the falling edge
    task automatic send_cmd(input csr_cmd_t c, input csr_addr_t addr, input xlen_t value);
        @(negedge clk);
        csr_valid   = 1'b1;
        csr_cmd     = c;
        csr_addr    = addr;
        csr_operand = value;
        csr_pc      = pc;
        pc          = pc + 32'd4;
        @(posedge clk);
        trap_seen = trap_flg;
    endtask

    task automatic write_csr(input csr_addr_t addr, input xlen_t value);
        send_cmd(CMD_W, addr, value);
    endtask

    task automatic read_csr(input csr_addr_t addr);
        send_cmd(CMD_S, addr, '0); // Set with zero leaves the value
    endtask

    // Idle cycle that also moves the timer inputs
    task automatic set_timer(input dword_t now, input dword_t cmp);
        @(negedge clk);
        csr_valid = 1'b0;
        csr_cmd   = CMD_NONE;
        mtime     = now;
        mtimecmp  = cmp;
    endtask

    task automatic wait_timer_trap;
        int tries;
        tries = 0;
        trap_seen = 1'b0;
        while (!trap_seen && tries < 2) begin
            send_cmd(CMD_NONE, ADDR_MSCRATCH, '0);
            tries++;
        end
        if (!trap_seen) begin
            seq_errors++;
            $display("timer interrupt was not taken within two commands of the compare match");
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the sequences finished", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        csr_valid   = 1'b0;
        csr_cmd     = CMD_NONE;
        csr_addr    = '0;
        csr_operand = '0;
        csr_pc      = '0;
        mtime       = '0;
        mtimecmp    = '1; // Compare far away
        seed        = 7;
        seq_errors  = 0;
        pc          = 32'h0000_1000;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;

        // Random read-modify-write on mscratch, each followed by a read
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd     = $random(seed);
            operand = $random(seed);
            case (rnd[1:0])
                2'd1:    cmd = CMD_S;
                2'd2:    cmd = CMD_C;
                default: cmd = CMD_W;
            endcase
            send_cmd(cmd, ADDR_MSCRATCH, operand);
            read_csr(ADDR_MSCRATCH);
        end

        // misa is constant, mepc drops bits 1:0, unknown reads zero
        read_csr(ADDR_MISA);
        write_csr(ADDR_MISA, $random(seed));
        read_csr(ADDR_MISA);
        write_csr(ADDR_MEPC, 32'h1234_5677);
        read_csr(ADDR_MEPC);
        read_csr(12'h7c0);
        read_csr(12'h3a0);

        // M-mode ecall into a direct vector
        write_csr(ADDR_MTVEC, 32'h0000_0200);
        send_cmd(CMD_ECALL, '0, '0);
        read_csr(ADDR_MCAUSE);
        read_csr(ADDR_MEPC);

        // MRET to U, denied access, then a U-mode ecall back to M
        write_csr(ADDR_MSTATUS, '0); // MPP = U
        write_csr(ADDR_MEPC, 32'h0000_2000);
        send_cmd(CMD_MRET, '0, '0);
        write_csr(ADDR_MSCRATCH, 32'hdead_beef);
        read_csr(ADDR_MISA);
        send_cmd(CMD_ECALL, '0, '0);
        read_csr(ADDR_MCAUSE);
        read_csr(ADDR_MSCRATCH);

        // Timer interrupt through a vectored mtvec
        write_csr(ADDR_MTVEC, 32'h0000_0301);
        write_csr(ADDR_MIE, 32'h0000_0080);
        send_cmd(CMD_S, ADDR_MSTATUS, 32'h0000_0008);
        set_timer(64'd200, 64'd100);
        wait_timer_trap();
        read_csr(ADDR_MCAUSE);
        read_csr(ADDR_MIP);
        set_timer(64'd0, '1);

        repeat (2) @(negedge clk);
        $display("errors: %0d checker mismatches, %0d sequence failures", mismatches, seq_errors);
        if (mismatches == 0 && seq_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== list.f ====
common/csr_pkg.sv
common/csr_rw_if.sv
common/trap_if.sv
src/csr_access.sv
src/csr_file.sv
src/trap_ctrl.sv
src/csr_unit.sv
tb/csr_assertions.sv
tb/csr_checker.sv
tb/tb_csr_unit.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_csr_unit

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

$(SIM): list.f $(wildcard common/*.sv src/*.sv tb/*.sv)
	verilator --binary --timing --assert --top-module tb_csr_unit -f list.f

clean:
	rm -rf obj_dir
